/* puzzle_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// puzzle fifo
// single clock, show-ahead fifo of whole grids
// head entry always on q, async clear of pointers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module puzzle_fifo
	import sudoku_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              wr,
	input  logic              rd,
	input  logic [GRID_W-1:0] data,
	output logic [GRID_W-1:0] q,
	output logic              empty,
	output logic              full
);

	// grid storage
	logic [GRID_W-1:0]  mem [FIFO_DEPTH];
	logic [FIFO_PW-1:0] wr_ptr;
	logic [FIFO_PW-1:0] rd_ptr;
	logic [FIFO_CW-1:0] count;
	logic               do_wr;
	logic               do_rd;

	// write when full and read when empty are dropped
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign empty = (count == '0);
	assign full  = (count == FIFO_CW'(FIFO_DEPTH));

	// show-ahead: head is visible without a read strobe
	assign q = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= data;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// pointers wrap at the depth, which need not be a power of two
			if (do_wr)
				wr_ptr <= (wr_ptr == FIFO_PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == FIFO_PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// occupancy, a simultaneous push and pop leaves it alone
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the sudoku testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_sudoku \
	-Mdir obj_dir -o tb_sudoku
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sudoku > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sudoku.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sudoku engine top level
// input fifo, solver core, output fifo and grid
// checker; puzzles come in on puzzle_in and leave
// on puzzle_out flagged as solution or give-up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sudoku
	import sudoku_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [GRID_W-1:0] puzzle_in,
	output logic [GRID_W-1:0] puzzle_out,
	output logic              puzzle_oe,
	output logic              next_puzzle,
	output logic              solution,
	output logic              give_up
);

	// input fifo side
	logic [GRID_W-1:0] in_q;
	logic              in_empty;
	logic              in_full;

	// output fifo side
	logic [GRID_W-1:0] core_grid;
	logic [GRID_W-1:0] out_q;
	logic              out_empty;
	logic              out_full;

	// core control
	logic              core_go;
	logic              core_read;
	logic              core_done;
	logic              grid_ok;

	puzzle_fifo i_in_fifo (
		.clk   (clk),
		.rst   (rst),
		.wr    (next_puzzle),
		.rd    (core_read),
		.data  (puzzle_in),
		.q     (in_q),
		.empty (in_empty),
		.full  (in_full)
	);

	// start latch: wait for the first full input fifo, then run for good
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			core_go <= 1'b0;
		else if (in_full)
			core_go <= 1'b1;
	end

	// core holds in idle while the output fifo has no room
	sudoku_core i_core (
		.clk          (clk),
		.rst          (rst),
		.go           (core_go),
		.puzzle_avail (!in_empty && !out_full),
		.puzzle_in    (in_q),
		.puzzle_out   (core_grid),
		.read_puzzle  (core_read),
		.done_puzzle  (core_done)
	);

	// every cycle with a grid shown is a pop
	puzzle_fifo i_out_fifo (
		.clk   (clk),
		.rst   (rst),
		.wr    (core_done),
		.rd    (puzzle_oe),
		.data  (core_grid),
		.q     (out_q),
		.empty (out_empty),
		.full  (out_full)
	);

	sudoku_solution i_check (
		.puzzle_ans (out_q),
		.solution   (grid_ok)
	);

	assign puzzle_oe   = !out_empty;
	// never ask for a puzzle while a grid is being shown
	assign next_puzzle = !puzzle_oe && !in_full;
	assign puzzle_out  = puzzle_oe ? out_q : '0;
	assign solution    = puzzle_oe && grid_ok;
	assign give_up     = puzzle_oe && !grid_ok;

endmodule

/* sudoku_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sudoku solver core
// loads a grid, sweeps one cell per cycle and fills
// cells that have a single candidate digit; stops
// when a pass fills nothing or the grid is full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sudoku_core
	import sudoku_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              go,
	input  logic              puzzle_avail,
	input  logic [GRID_W-1:0] puzzle_in,
	output logic [GRID_W-1:0] puzzle_out,
	output logic              read_puzzle,
	output logic              done_puzzle
);

	core_state_t       state;
	logic [GRID_W-1:0] grid;

	// scan position
	logic [ROW_W-1:0]  row;
	logic [ROW_W-1:0]  col;
	logic [IDX_W-1:0]  cell_idx;
	logic              last_cell;

	// pass bookkeeping
	logic              filled;
	logic              unknown;
	logic              pass_filled;
	logic              pass_unknown;

	// candidate logic for the current cell
	logic [CELL_W-1:0] cur_cell;
	logic [GRID_N-1:0] used;
	logic [GRID_N-1:0] cand;
	logic              single;
	logic              fill_now;
	logic [CELL_W-1:0] fill_digit;

	assign cell_idx  = IDX_W'(row * GRID_N + col);
	assign last_cell = (row == ROW_W'(GRID_N - 1)) && (col == ROW_W'(GRID_N - 1));
	assign cur_cell  = get_cell(grid, row, col);

	// digits already taken in the row, column and 3x3 box
	always_comb
	begin
		int br;
		int bc;
		br   = (int'(row) / 3) * 3;
		bc   = (int'(col) / 3) * 3;
		used = '0;
		for (int k = 0; k < GRID_N; k++)
		begin
			used |= cell_mask(get_cell(grid, row, k));
			used |= cell_mask(get_cell(grid, k, col));
			used |= cell_mask(get_cell(grid, br + k / 3, bc + k % 3));
		end
	end

	assign cand   = ~used;
	// exactly one bit left
	assign single = (cand != '0) && ((cand & (cand - 1'b1)) == '0);

	// position of the single candidate, as a digit 1..9
	always_comb
	begin
		fill_digit = '0;
		for (int k = 0; k < GRID_N; k++)
			if (cand[k])
				fill_digit = CELL_W'(k + 1);
	end

	// only unknowns are written, givens stay as loaded
	assign fill_now = (state == CORE_SCAN) && (cur_cell == '0) && single;

	// pass totals including the cell being scanned now
	assign pass_filled  = filled || fill_now;
	assign pass_unknown = unknown || ((cur_cell == '0) && !fill_now);

	// pop the input fifo in the same cycle that we capture its head
	assign read_puzzle = (state == CORE_IDLE) && go && puzzle_avail;
	assign done_puzzle = (state == CORE_EMIT);
	assign puzzle_out  = grid;

	// working grid
	always_ff @(posedge clk)
	begin
		if (read_puzzle)
			grid <= puzzle_in;
		else if (fill_now)
			grid[GRID_W-1 - int'(cell_idx) * CELL_W -: CELL_W] <= fill_digit;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state   <= CORE_IDLE;
			row     <= '0;
			col     <= '0;
			filled  <= 1'b0;
			unknown <= 1'b0;
		end
		else
		begin
			case (state)
				CORE_IDLE:
				begin
					if (read_puzzle)
					begin
						state   <= CORE_SCAN;
						row     <= '0;
						col     <= '0;
						filled  <= 1'b0;
						unknown <= 1'b0;
					end
				end
				CORE_SCAN:
				begin
					filled  <= pass_filled;
					unknown <= pass_unknown;
					if (last_cell)
					begin
						// no progress or nothing left to do, hand the grid on
						if (!pass_filled || !pass_unknown)
							state <= CORE_EMIT;
						row     <= '0;
						col     <= '0;
						filled  <= 1'b0;
						unknown <= 1'b0;
					end
					else if (col == ROW_W'(GRID_N - 1))
					begin
						col <= '0;
						row <= row + 1'b1;
					end
					else
						col <= col + 1'b1;
				end
				// one cycle with the finished grid on puzzle_out
				CORE_EMIT:
					state <= CORE_IDLE;
				default:
					state <= CORE_IDLE;
			endcase
		end
	end

endmodule

/* sudoku_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sudoku engine package
// grid geometry, fifo depth, solver states and the
// cell helpers shared by the core and the checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sudoku_pkg;

	// grid geometry
	localparam int CELL_W     = 4;
	localparam int GRID_N     = 9;
	localparam int GRID_CELLS = GRID_N * GRID_N;
	localparam int GRID_W     = GRID_CELLS * CELL_W;

	// row/column counter and flat cell index widths
	localparam int ROW_W = $clog2(GRID_N);
	localparam int IDX_W = $clog2(GRID_CELLS);

	// all nine digits present
	localparam logic [GRID_N-1:0] DIGIT_ALL = '1;

	// puzzles per fifo, any depth of 1 or more works
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PW    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

	// solver core states
	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_SCAN,
		CORE_EMIT
	} core_state_t;

	// cell at row r, column c; row 0 col 0 sits at the msb end
	function automatic logic [CELL_W-1:0] get_cell(input logic [GRID_W-1:0] grid,
		input int r, input int c);
		return grid[GRID_W-1 - (r * GRID_N + c) * CELL_W -: CELL_W];
	endfunction

	// one-hot digit mask, bit 0 is digit 1
	// zero and the unused codes 10..15 give an empty mask
	function automatic logic [GRID_N-1:0] cell_mask(input logic [CELL_W-1:0] v);
		logic [GRID_N-1:0] m;
		m = '0;
		if (v >= 1 && v <= GRID_N)
			m[v-1] = 1'b1;
		return m;
	endfunction

endpackage

/* sudoku_solution.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sudoku grid checker
// combinational, flags a complete valid grid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sudoku_solution
	import sudoku_pkg::*;
(
	input  logic [GRID_W-1:0] puzzle_ans,
	output logic              solution
);

	// per-group digit masks and their verdicts
	logic [GRID_N-1:0] row_m [GRID_N];
	logic [GRID_N-1:0] col_m [GRID_N];
	logic [GRID_N-1:0] box_m [GRID_N];
	logic [GRID_N-1:0] row_ok;
	logic [GRID_N-1:0] col_ok;
	logic [GRID_N-1:0] box_ok;

	// nine cells covering all nine digits means no zero,
	// no code above 9 and no duplicate in the group
	always_comb
	begin
		for (int g = 0; g < GRID_N; g++)
		begin
			row_m[g] = '0;
			col_m[g] = '0;
			box_m[g] = '0;
			for (int k = 0; k < GRID_N; k++)
			begin
				row_m[g] |= cell_mask(get_cell(puzzle_ans, g, k));
				col_m[g] |= cell_mask(get_cell(puzzle_ans, k, g));
				// box g: boxes numbered row-major, k walks inside the box
				box_m[g] |= cell_mask(get_cell(puzzle_ans,
					(g / 3) * 3 + k / 3, (g % 3) * 3 + k % 3));
			end
		end
	end

	always_comb
	begin
		for (int g = 0; g < GRID_N; g++)
		begin
			row_ok[g] = (row_m[g] == DIGIT_ALL);
			col_ok[g] = (col_m[g] == DIGIT_ALL);
			box_ok[g] = (box_m[g] == DIGIT_ALL);
		end
	end

	// every one of the 27 groups must be complete
	assign solution = (&row_ok) && (&col_ok) && (&box_ok);

endmodule

/* tb_puzzles.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sudoku testbench data
// puzzle table fed to the engine, the grid each
// one must come back as, and the expected verdict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_PUZZLES_SVH
`define TB_PUZZLES_SVH

localparam int N_PUZ = 5;

// one hex digit per cell, row 0 col 0 first, one 36-bit group per row
localparam logic [GRID_W-1:0] PUZ_IN [N_PUZ] = '{
	// diagonal blanked, every blank is alone in its row
	{36'h023456789, 36'h406789123, 36'h780123456,
	 36'h234067891, 36'h567801234, 36'h891230567,
	 36'h345678012, 36'h678912305, 36'h912345670},
	// row 4 and the top left cell blanked
	{36'h034678912, 36'h672195348, 36'h198342567,
	 36'h859761423, 36'h000000000, 36'h713924856,
	 36'h961537284, 36'h287419635, 36'h345286179},
	// already complete and valid
	{36'h534678912, 36'h672195348, 36'h198342567,
	 36'h859761423, 36'h426853791, 36'h713924856,
	 36'h961537284, 36'h287419635, 36'h345286179},
	// complete, but row 0 holds the digit 2 twice
	{36'h223456789, 36'h456789123, 36'h789123456,
	 36'h234567891, 36'h567891234, 36'h891234567,
	 36'h345678912, 36'h678912345, 36'h912345678},
	// empty grid
	'0
};

localparam logic [GRID_W-1:0] PUZ_EXP [N_PUZ] = '{
	{36'h123456789, 36'h456789123, 36'h789123456,
	 36'h234567891, 36'h567891234, 36'h891234567,
	 36'h345678912, 36'h678912345, 36'h912345678},
	{36'h534678912, 36'h672195348, 36'h198342567,
	 36'h859761423, 36'h426853791, 36'h713924856,
	 36'h961537284, 36'h287419635, 36'h345286179},
	{36'h534678912, 36'h672195348, 36'h198342567,
	 36'h859761423, 36'h426853791, 36'h713924856,
	 36'h961537284, 36'h287419635, 36'h345286179},
	// give-ups come back untouched
	{36'h223456789, 36'h456789123, 36'h789123456,
	 36'h234567891, 36'h567891234, 36'h891234567,
	 36'h345678912, 36'h678912345, 36'h912345678},
	'0
};

localparam bit EXP_SOL [N_PUZ] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0};

`endif

/* tb_sudoku.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sudoku engine testbench
// feeds the puzzle table, scoreboards every grid
// that leaves the engine and checks the strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_sudoku
	import sudoku_pkg::*;
();

	`include "tb_puzzles.svh"

	// grids to see before the run ends
	localparam int NUM_OUT = 16;
	// per puzzle at most 82 passes of 81 cells plus load and emit
	localparam int WATCH_CYCLES =
		(NUM_OUT + 2 * FIFO_DEPTH + 1) * (GRID_CELLS * (GRID_CELLS + 1) + 2) + 200;

	logic              clk;
	logic              rst;
	logic [GRID_W-1:0] puzzle_in = PUZ_IN[0];
	logic [GRID_W-1:0] puzzle_out;
	logic              puzzle_oe;
	logic              next_puzzle;
	logic              solution;
	logic              give_up;

	// scoreboard of table indices in acceptance order
	int     sb_q [$];
	// correct returns per table entry
	int     seen [N_PUZ];
	int     cur_idx  = 0;
	int     accepted = 0;
	int     outputs  = 0;
	int     errors   = 0;
	int     cycles   = 0;
	integer seed     = 91692;

	sudoku i_sudoku (
		.clk         (clk),
		.rst         (rst),
		.puzzle_in   (puzzle_in),
		.puzzle_out  (puzzle_out),
		.puzzle_oe   (puzzle_oe),
		.next_puzzle (next_puzzle),
		.solution    (solution),
		.give_up     (give_up)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

	task automatic verify_bit(input string name, input logic exp, input logic act);
		assert (act === exp)
		else
		begin
			errors++;
			$display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic compare_grid(input string name, input logic [GRID_W-1:0] exp,
		input logic [GRID_W-1:0] act);
		assert (act === exp)
		else
		begin
			errors++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic require_true(input bit cond, input string msg);
		assert (cond)
		else
		begin
			errors++;
			$display("Error at %0t: %s", $time, msg);
		end
	endtask

	// every nonzero cell of the input must survive into the result
	function automatic bit givens_kept(input logic [GRID_W-1:0] given,
		input logic [GRID_W-1:0] result);
		logic [CELL_W-1:0] g;
		for (int i = 0; i < GRID_CELLS; i++)
		begin
			g = given[GRID_W-1 - i * CELL_W -: CELL_W];
			if (g != '0 && result[GRID_W-1 - i * CELL_W -: CELL_W] != g)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic print_summary();
		$display("Summary: %0d puzzles accepted, %0d grids out, %0d errors",
			accepted, outputs, errors);
	endtask

	// output checks run before the feeder and see pre-edge values
	always @(posedge clk)
	begin
		int e;
		int rnd;
		int nxt;
		if (rst)
		begin
			// outputs are settled from the second reset edge on
			if (cycles > 0)
			begin
				verify_bit("puzzle_oe", 1'b0, puzzle_oe);
				verify_bit("solution", 1'b0, solution);
				verify_bit("give_up", 1'b0, give_up);
				// an empty input fifo already asks for a puzzle
				verify_bit("next_puzzle", 1'b1, next_puzzle);
				compare_grid("puzzle_out", '0, puzzle_out);
			end
		end
		else
		begin
			require_true(!(next_puzzle && puzzle_oe), "next_puzzle high while a grid is shown");
			require_true(accepted - outputs <= 2 * FIFO_DEPTH + 1,
				"more puzzles in flight than two FIFOs and the core hold");
			// input fifo plus the one grid inside the core
			if (outputs == 0)
				require_true(accepted <= FIFO_DEPTH + 1, "too many puzzles before first output");
			if (puzzle_oe)
			begin
				require_true(outputs > 0 || accepted >= FIFO_DEPTH,
					"output before the input FIFO was first filled");
				require_true(solution != give_up, "solution and give_up not exclusive");
				if (sb_q.size() == 0)
					require_true(1'b0, "grid came out with no puzzle outstanding");
				else
				begin
					e = sb_q.pop_front();
					require_true(givens_kept(PUZ_IN[e], puzzle_out), "a given cell was changed");
					compare_grid("puzzle_out", PUZ_EXP[e], puzzle_out);
					verify_bit("solution", EXP_SOL[e], solution);
					verify_bit("give_up", !EXP_SOL[e], give_up);
					if (puzzle_out === PUZ_EXP[e] && solution === EXP_SOL[e])
						seen[e]++;
				end
				outputs++;
			end
			else
			begin
				verify_bit("solution", 1'b0, solution);
				verify_bit("give_up", 1'b0, give_up);
				compare_grid("puzzle_out", '0, puzzle_out);
			end
			// the fifo takes puzzle_in at this edge
			if (next_puzzle)
			begin
				sb_q.push_back(cur_idx);
				accepted++;
				nxt = (cur_idx + 1) % N_PUZ;
				rnd = $random(seed) & 32'h7fff_ffff;
				// random jumps only after one plain pass over the table
				if (accepted > N_PUZ && rnd % 4 == 0)
					nxt = (rnd / 4) % N_PUZ;
				cur_idx = nxt;
				puzzle_in <= PUZ_IN[nxt];
			end
		end
		cycles++;
	end

	initial
	begin
		while (outputs < NUM_OUT)
			@(negedge clk);
		repeat (2) @(negedge clk);
		require_true(accepted == outputs + sb_q.size(), "accepted and returned counts disagree");
		for (int i = 0; i < N_PUZ; i++)
			require_true(seen[i] > 0, "a table entry never came back correct");
		print_summary();
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (WATCH_CYCLES) @(posedge clk);
		errors++;
		$display("Error at %0t: watchdog expired with %0d of %0d grids out",
			$time, outputs, NUM_OUT);
		print_summary();
		$display("Something failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
sudoku_pkg.sv
puzzle_fifo.sv
sudoku_core.sv
sudoku_solution.sv
sudoku.sv
tb_sudoku.sv
